// File: source/forthJump_defs.svh
`ifndef FORTHJUMP_DEFS_SVH
`define FORTHJUMP_DEFS_SVH

// width of a data word and of an address.
`define FJ_DATA_WIDTH 16

// size of the register file.
`define FJ_REG_COUNT 8

// index of the register that receives the return address.
`define FJ_LINK_REG 7

// pc value after reset.
`define FJ_RESET_VECTOR 0

// group field value for the jump group.
`define FJ_GROUP_JUMP 2

`endif

// File: source/isaPkg.sv
package isaPkg;

	// jump modes, in the encoding of the JPF field.
	typedef enum logic [1:0] {
		JP_ABS_REG  = 2'b00,
		JP_IND_REG  = 2'b01,
		JP_ABS_HERE = 2'b10,
		JP_REL_HERE = 2'b11
	} jumpMode_t;

	// condition flag select, in the encoding of the CCF field.
	typedef enum logic [1:0] {
		CC_ZERO   = 2'b00,
		CC_CARRY  = 2'b01,
		CC_SIGN   = 2'b10,
		CC_PARITY = 2'b11
	} ccSel_t;

	// the instruction word, msb first.
	typedef struct packed {
		logic [1:0] groupF;
		logic [1:0] skipF;
		ccSel_t     ccF;
		jumpMode_t  jpF;
		logic       jlF;
		logic [3:0] unusedF;
		logic [2:0] argB;
	} instrFields_t;

	typedef struct packed {
		logic zero;
		logic carry;
		logic sign;
		logic parity;
	} ccFlags_t;

endpackage

// File: source/ctrlPkg.sv
package ctrlPkg;

	// one instruction takes one pass through these phases.
	typedef enum logic [1:0] {
		PH_FETCH   = 2'd0,
		PH_DECODE  = 2'd1,
		PH_EXECUTE = 2'd2,
		PH_COMMIT  = 2'd3
	} phase_t;

	typedef enum logic [1:0] {
		BASE_ZERO = 2'd0,
		BASE_PC   = 2'd1,
		BASE_REGB = 2'd2
	} pcBaseSel_t;

	typedef enum logic [1:0] {
		OFF_ZERO = 2'd0,
		OFF_TWO  = 2'd1,
		OFF_FOUR = 2'd2,
		OFF_DIN  = 2'd3
	} pcOffsetSel_t;

	// ADDR_HERE points at the inline word that follows the opcode.
	typedef enum logic {
		ADDR_PC   = 1'b0,
		ADDR_HERE = 1'b1
	} addrSel_t;

	typedef struct packed {
		pcBaseSel_t   pcBase;
		pcOffsetSel_t pcOffset;
		addrSel_t     addrSel;
		logic         addrFromRegB;
		logic         linkWrite;
		logic         busRead;
	} jumpCtrl_t;

endpackage

// File: source/phaseSequencer.sv
`timescale 1ns/10ps

module phaseSequencer (
	input  logic            CLK,
	input  logic            RESET,
	output ctrlPkg::phase_t phase
);
	import ctrlPkg::*;

	logic [1:0] phaseCount;

	// the counter wraps from COMMIT back to FETCH on its own.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			phaseCount <= 2'(PH_FETCH);
		end else begin
			phaseCount <= phaseCount + 2'd1;
		end
	end

	assign phase = phase_t'(phaseCount);

endmodule

// File: source/jumpGroupDecoder.sv
`timescale 1ns/10ps
`include "forthJump_defs.svh"

module jumpGroupDecoder (
	input  logic                 CLK,
	input  logic                 RESET,
	input  isaPkg::instrFields_t instr,
	input  isaPkg::ccFlags_t     flags,
	input  ctrlPkg::phase_t      phase,
	output ctrlPkg::jumpCtrl_t   ctrl,
	output logic [2:0]           regBAddr
);
	import isaPkg::*;
	import ctrlPkg::*;

	instrFields_t instrReg;
	logic         isJump;
	logic         ccBit;
	logic         takenNow;
	logic         needsRead;
	logic         hasInline;
	logic         takenReg;
	logic         busReadReg;

	always_ff @(posedge CLK) begin
		if (phase == PH_FETCH) begin
			instrReg <= instr;
		end
	end

	assign isJump    = (instrReg.groupF == 2'(`FJ_GROUP_JUMP));
	assign needsRead = (instrReg.jpF != JP_ABS_REG);
	assign hasInline = (instrReg.jpF == JP_ABS_HERE) || (instrReg.jpF == JP_REL_HERE);
	assign regBAddr  = instrReg.argB;

	always_comb begin
		case (instrReg.ccF)
			CC_ZERO:  ccBit = flags.zero;
			CC_CARRY: ccBit = flags.carry;
			CC_SIGN:  ccBit = flags.sign;
			default:  ccBit = flags.parity;
		endcase
	end

	// skip bit 1 clear means always; otherwise bit 0 inverts the flag.
	assign takenNow = ~instrReg.skipF[1] | (ccBit ^ instrReg.skipF[0]);

	// flags are only valid in DECODE, so the decision is kept until the next one.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			takenReg   <= 1'b0;
			busReadReg <= 1'b0;
		end else begin
			if (phase == PH_DECODE) begin
				takenReg <= isJump & takenNow;
			end
			busReadReg <= (phase == PH_DECODE) & isJump & takenNow & needsRead;
		end
	end

	always_comb begin
		ctrl.pcBase       = BASE_PC;
		ctrl.pcOffset     = OFF_TWO;
		ctrl.addrSel      = ADDR_PC;
		ctrl.addrFromRegB = 1'b0;
		ctrl.linkWrite    = (phase == PH_COMMIT) & takenReg & instrReg.jlF;
		ctrl.busRead      = busReadReg;

		if (isJump) begin
			ctrl.addrSel      = hasInline ? ADDR_HERE : ADDR_PC;
			ctrl.addrFromRegB = (instrReg.jpF == JP_IND_REG);

			if (takenReg) begin
				case (instrReg.jpF)
					JP_ABS_REG: begin
						ctrl.pcBase   = BASE_REGB;
						ctrl.pcOffset = OFF_ZERO;
					end
					JP_IND_REG, JP_ABS_HERE: begin
						ctrl.pcBase   = BASE_ZERO;
						ctrl.pcOffset = OFF_DIN;
					end
					default: begin
						ctrl.pcBase   = BASE_PC;
						ctrl.pcOffset = OFF_DIN;
					end
				endcase
			end else begin
				// a skipped jump still steps over its inline word.
				ctrl.pcOffset = hasInline ? OFF_FOUR : OFF_TWO;
			end
		end
	end

endmodule

// File: source/registerFile.sv
`timescale 1ns/10ps
`include "forthJump_defs.svh"

module registerFile (
	input  logic                              CLK,
	input  logic                              RESET,
	input  logic                              wrEn,
	input  logic [$clog2(`FJ_REG_COUNT)-1:0] wrAddr,
	input  logic [`FJ_DATA_WIDTH-1:0]         wrData,
	input  logic                              linkWrite,
	input  logic [`FJ_DATA_WIDTH-1:0]         linkData,
	input  logic [$clog2(`FJ_REG_COUNT)-1:0] rdAddr,
	output logic [`FJ_DATA_WIDTH-1:0]         rdData
);

	logic [`FJ_DATA_WIDTH-1:0] regs [`FJ_REG_COUNT];

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			for (int i = 0; i < `FJ_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wrEn) begin
				regs[wrAddr] <= wrData;
			end
			// the later assignment wins when both target the link register.
			if (linkWrite) begin
				regs[`FJ_LINK_REG] <= linkData;
			end
		end
	end

	assign rdData = regs[rdAddr];

endmodule

// File: source/programCounter.sv
`timescale 1ns/10ps
`include "forthJump_defs.svh"

module programCounter (
	input  logic                      CLK,
	input  logic                      RESET,
	input  ctrlPkg::phase_t           phase,
	input  ctrlPkg::jumpCtrl_t        ctrl,
	input  logic [`FJ_DATA_WIDTH-1:0] regBData,
	input  logic [`FJ_DATA_WIDTH-1:0] din,
	output logic [`FJ_DATA_WIDTH-1:0] pc,
	output logic [`FJ_DATA_WIDTH-1:0] addr,
	output logic [`FJ_DATA_WIDTH-1:0] retAddr
);
	import ctrlPkg::*;

	logic [`FJ_DATA_WIDTH-1:0] baseVal;
	logic [`FJ_DATA_WIDTH-1:0] offsetVal;
	logic [`FJ_DATA_WIDTH-1:0] pcNext;
	logic [`FJ_DATA_WIDTH-1:0] pcPlus2;
	logic [`FJ_DATA_WIDTH-1:0] pcPlus4;

	assign pcPlus2 = pc + `FJ_DATA_WIDTH'(2);
	assign pcPlus4 = pc + `FJ_DATA_WIDTH'(4);

	always_comb begin
		case (ctrl.pcBase)
			BASE_ZERO: baseVal = '0;
			BASE_REGB: baseVal = regBData;
			default:   baseVal = pc;
		endcase
	end

	always_comb begin
		case (ctrl.pcOffset)
			OFF_ZERO: offsetVal = '0;
			OFF_TWO:  offsetVal = `FJ_DATA_WIDTH'(2);
			OFF_FOUR: offsetVal = `FJ_DATA_WIDTH'(4);
			default:  offsetVal = din;
		endcase
	end

	// relative jumps wrap around the address space.
	assign pcNext = baseVal + offsetVal;

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			pc <= `FJ_DATA_WIDTH'(`FJ_RESET_VECTOR);
		end else if (phase == PH_COMMIT) begin
			pc <= pcNext;
		end
	end

	// the inline word sits right after the opcode.
	assign addr    = ctrl.addrFromRegB ? regBData :
		(ctrl.addrSel == ADDR_HERE) ? pcPlus2 : pc;

	assign retAddr = (ctrl.addrSel == ADDR_HERE) ? pcPlus4 : pcPlus2;

endmodule

// File: source/jumpUnit.sv
`timescale 1ns/10ps
`include "forthJump_defs.svh"

module jumpUnit (
	input  logic                              CLK,
	input  logic                              RESET,
	input  isaPkg::instrFields_t              instr,
	input  isaPkg::ccFlags_t                  flags,
	input  logic [`FJ_DATA_WIDTH-1:0]         din,
	input  logic                              wrEn,
	input  logic [$clog2(`FJ_REG_COUNT)-1:0] wrAddr,
	input  logic [`FJ_DATA_WIDTH-1:0]         wrData,
	output ctrlPkg::phase_t                   phase,
	output logic [`FJ_DATA_WIDTH-1:0]         pc,
	output logic [`FJ_DATA_WIDTH-1:0]         addr,
	output logic                              busRead
);
	import ctrlPkg::*;

	jumpCtrl_t                 ctrl;
	logic [2:0]                regBAddr;
	logic [`FJ_DATA_WIDTH-1:0] regBData;
	logic [`FJ_DATA_WIDTH-1:0] retAddr;

	phaseSequencer u_phaseSequencer (
		.CLK   (CLK),
		.RESET (RESET),
		.phase (phase)
	);

	jumpGroupDecoder u_jumpGroupDecoder (
		.CLK      (CLK),
		.RESET    (RESET),
		.instr    (instr),
		.flags    (flags),
		.phase    (phase),
		.ctrl     (ctrl),
		.regBAddr (regBAddr)
	);

	// the return address doubles as the link data.
	registerFile u_registerFile (
		.CLK       (CLK),
		.RESET     (RESET),
		.wrEn      (wrEn),
		.wrAddr    (wrAddr),
		.wrData    (wrData),
		.linkWrite (ctrl.linkWrite),
		.linkData  (retAddr),
		.rdAddr    (regBAddr),
		.rdData    (regBData)
	);

	programCounter u_programCounter (
		.CLK      (CLK),
		.RESET    (RESET),
		.phase    (phase),
		.ctrl     (ctrl),
		.regBData (regBData),
		.din      (din),
		.pc       (pc),
		.addr     (addr),
		.retAddr  (retAddr)
	);

	assign busRead = ctrl.busRead;

endmodule

// File: test/jumpUnit_props.sv
`timescale 1ns/10ps
`include "forthJump_defs.svh"

module jumpUnitProps (
	input logic                      CLK,
	input logic                      RESET,
	input ctrlPkg::phase_t           phase,
	input logic                      busRead,
	input logic [`FJ_DATA_WIDTH-1:0] pc
);
	import ctrlPkg::*;

	// the phase steps by one every cycle and wraps after COMMIT.
	property phaseStepsInOrder;
		@(posedge CLK) disable iff (RESET)
			1'b1 |=> (2'(phase) == 2'($past(phase)) + 2'd1);
	endproperty

	property readOnlyInExecute;
		@(posedge CLK) disable iff (RESET) busRead |-> (phase == PH_EXECUTE);
	endproperty

	// pc is loaded at the COMMIT edge and nowhere else.
	property pcMovesAfterCommit;
		@(posedge CLK) disable iff (RESET) !$stable(pc) |-> ($past(phase) == PH_COMMIT);
	endproperty

	assert property (phaseStepsInOrder) else $error("phase skipped or repeated a step");
	assert property (readOnlyInExecute) else $error("busRead high outside EXECUTE");
	assert property (pcMovesAfterCommit) else $error("pc changed outside the COMMIT edge");

endmodule

// File: test/jumpUnitTb.sv
`timescale 1ns/10ps
`include "forthJump_defs.svh"

module jumpUnitTb;
	import isaPkg::*;
	import ctrlPkg::*;

	// expRead is the bus read expected during EXECUTE.
	typedef struct packed {
		logic [15:0] instr;
		logic [3:0]  flags;
		logic [15:0] din;
		logic        expRead;
	} stimRow_t;

	logic                      CLK;
	logic                      RESET;
	instrFields_t              instr;
	ccFlags_t                  flags;
	logic [`FJ_DATA_WIDTH-1:0] din;
	logic                      wrEn;
	logic [2:0]                wrAddr;
	logic [`FJ_DATA_WIDTH-1:0] wrData;
	phase_t                    phase;
	logic [`FJ_DATA_WIDTH-1:0] pc;
	logic [`FJ_DATA_WIDTH-1:0] addr;
	logic                      busRead;

	stimRow_t                  stimTable[$];
	logic [`FJ_DATA_WIDTH-1:0] modelPc;
	logic [`FJ_DATA_WIDTH-1:0] modelRegs [`FJ_REG_COUNT];
	integer                    seed = 32'hf00e3e68;
	int                        cycleCount = 0;
	int                        cycleLimit = 1000;

	jumpUnit u_jumpUnit (
		.CLK(CLK), .RESET(RESET), .instr(instr), .flags(flags), .din(din),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.phase(phase), .pc(pc), .addr(addr), .busRead(busRead)
	);

	bind jumpUnit jumpUnitProps u_jumpUnitProps (
		.CLK(CLK), .RESET(RESET), .phase(phase), .busRead(busRead), .pc(pc)
	);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK;

	always @(posedge CLK) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

	task automatic checkValue(input string name, input logic [15:0] actual,
			input logic [15:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got %h, expected %h", name, actual, expected);
			$display("*** FAILED ***");
			$fatal(1);
		end
	endtask

	function automatic logic [15:0] makeJump(input logic [1:0] skip, input logic [1:0] cc,
			input logic [1:0] mode, input logic link, input logic [2:0] b);
		return {2'b10, skip, cc, mode, link, 4'b0000, b};
	endfunction

	task automatic addRow(input logic [15:0] w, input logic [3:0] f, input logic [15:0] d,
			input logic rd);
		stimTable.push_back({w, f, d, rd});
	endtask

	// one instruction slot, entered and left on the falling edge in FETCH.
	task automatic applyInstruction(input stimRow_t row, input logic doWrite,
			input logic [2:0] regIdx, input logic [15:0] regVal);
		logic [1:0]  mode;
		logic [2:0]  b;
		logic        taken;
		logic [15:0] retPc;
		logic [15:0] nextPc;
		mode = row.instr[9:8];
		b = row.instr[2:0];
		checkValue("phase", 16'(phase), 16'(PH_FETCH));
		checkValue("pc", pc, modelPc);
		instr = row.instr;
		wrEn = doWrite;
		wrAddr = regIdx;
		wrData = regVal;
		if (doWrite)
			modelRegs[regIdx] = regVal;
		taken = (row.instr[15:14] == 2'b10) &&
			(!row.instr[13] || (row.flags[3 - row.instr[11:10]] ^ row.instr[12]));
		retPc = mode[1] ? modelPc + 16'd4 : modelPc + 16'd2;
		if (row.instr[15:14] != 2'b10)
			nextPc = modelPc + 16'd2;
		else if (!taken)
			nextPc = retPc;
		else if (mode == 2'b00)
			nextPc = modelRegs[b];
		else if (mode == 2'b11)
			nextPc = modelPc + row.din;
		else
			nextPc = row.din;
		@(negedge CLK);
		wrEn = 1'b0;
		flags = row.flags;
		checkValue("busRead", busRead, 16'd0);
		@(negedge CLK);
		din = row.din;
		checkValue("busRead", busRead, row.expRead);
		if (row.expRead)
			checkValue("addr", addr, (mode == 2'b01) ? modelRegs[b] : modelPc + 16'd2);
		@(negedge CLK);
		checkValue("busRead", busRead, 16'd0);
		@(negedge CLK);
		if (taken && row.instr[7])
			modelRegs[`FJ_LINK_REG] = retPc;
		modelPc = nextPc;
	endtask

	initial begin
		stimRow_t noopRow;
		instr = '0;
		flags = '0;
		din = '0;
		wrEn = 1'b0;
		wrAddr = '0;
		wrData = '0;
		RESET = 1'b1;
		noopRow = '0;
		// flags column is {zero, carry, sign, parity}.
		addRow(makeJump(2'b00, 2'd0, 2'b00, 1'b0, 3'd3), 4'b0000, 16'h0000, 1'b0);
		addRow(makeJump(2'b01, 2'd1, 2'b01, 1'b0, 3'd2), 4'b0100, 16'h1230, 1'b1);
		addRow(makeJump(2'b00, 2'd2, 2'b10, 1'b0, 3'd0), 4'b0000, 16'h0400, 1'b1);
		addRow(makeJump(2'b00, 2'd3, 2'b11, 1'b0, 3'd0), 4'b0000, 16'h0010, 1'b1);
		addRow(makeJump(2'b10, 2'd0, 2'b00, 1'b0, 3'd1), 4'b1000, 16'h0000, 1'b0);
		addRow(makeJump(2'b10, 2'd0, 2'b00, 1'b0, 3'd1), 4'b0000, 16'h0000, 1'b0);
		addRow(makeJump(2'b11, 2'd1, 2'b10, 1'b0, 3'd0), 4'b0000, 16'h0200, 1'b1);
		addRow(makeJump(2'b11, 2'd1, 2'b10, 1'b0, 3'd0), 4'b0100, 16'h0bad, 1'b0);
		addRow(makeJump(2'b10, 2'd2, 2'b11, 1'b0, 3'd0), 4'b0010, 16'hfff0, 1'b1);
		addRow(makeJump(2'b10, 2'd2, 2'b11, 1'b0, 3'd0), 4'b1101, 16'h0040, 1'b0);
		addRow(makeJump(2'b11, 2'd3, 2'b01, 1'b0, 3'd5), 4'b1110, 16'h0800, 1'b1);
		addRow(makeJump(2'b11, 2'd3, 2'b01, 1'b0, 3'd5), 4'b0001, 16'h0900, 1'b0);
		addRow(makeJump(2'b10, 2'd3, 2'b00, 1'b0, 3'd4), 4'b0001, 16'h0000, 1'b0);
		addRow(makeJump(2'b00, 2'd0, 2'b10, 1'b1, 3'd0), 4'b0000, 16'h0300, 1'b1);
		addRow(makeJump(2'b10, 2'd1, 2'b11, 1'b1, 3'd0), 4'b0000, 16'h0020, 1'b0);
		addRow(makeJump(2'b00, 2'd0, 2'b00, 1'b0, 3'd7), 4'b0000, 16'h0000, 1'b0);
		addRow(16'h3f87, 4'b1111, 16'hffff, 1'b0);
		addRow(16'hc1a5, 4'b0000, 16'h1234, 1'b0);
		addRow(makeJump(2'b01, 2'd0, 2'b01, 1'b1, 3'd6), 4'b1000, 16'h0a00, 1'b1);
		addRow(makeJump(2'b00, 2'd0, 2'b00, 1'b0, 3'd7), 4'b0000, 16'h0000, 1'b0);
		// seven preload slots plus the table, with margin for reset.
		cycleLimit = 4 * (stimTable.size() + 7) + 20;
		modelPc = `FJ_RESET_VECTOR;
		for (int r = 0; r < `FJ_REG_COUNT; r++)
			modelRegs[r] = '0;
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b0;
		checkValue("phase", 16'(phase), 16'(PH_FETCH));
		checkValue("pc", pc, 16'(`FJ_RESET_VECTOR));
		checkValue("busRead", busRead, 16'd0);
		for (int r = 0; r < `FJ_LINK_REG; r++)
			applyInstruction(noopRow, 1'b1, 3'(r), 16'($random(seed)));
		foreach (stimTable[i])
			applyInstruction(stimTable[i], 1'b0, 3'd0, 16'd0);
		checkValue("pc", pc, modelPc);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: forthJump.f
+incdir+source
source/isaPkg.sv
source/ctrlPkg.sv
source/phaseSequencer.sv
source/jumpGroupDecoder.sv
source/registerFile.sv
source/programCounter.sv
source/jumpUnit.sv
test/jumpUnit_props.sv
test/jumpUnitTb.sv

// File: Bender.yml
package:
  name: forthJump

sources:
  - include_dirs:
      - source
    files:
      - source/isaPkg.sv
      - source/ctrlPkg.sv
      - source/phaseSequencer.sv
      - source/jumpGroupDecoder.sv
      - source/registerFile.sv
      - source/programCounter.sv
      - source/jumpUnit.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/jumpUnit_props.sv
      - test/jumpUnitTb.sv
